//--- src/riscv_isa_pkg.sv
// RV32I encodings for the execute cluster
// major opcodes, funct3/funct7 codes and immediate extraction

package riscv_isa_pkg;

  //////////////////////////////////////////////////
  // major opcodes (insn[6:0])
  //////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // register-register
    OP_IMM = 7'b0010011,  // register-immediate
    LUI    = 7'b0110111,  // load upper immediate
    AUIPC  = 7'b0010111   // add upper immediate to pc
  } opcode_t;

  //////////////////////////////////////////////////
  // funct3 codes, shared by OP and OP-IMM
  //////////////////////////////////////////////////

  localparam logic [2:0] F3_ADD  = 3'b000;  // ADD/SUB/ADDI
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL/SRA, told apart by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 values
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

  //////////////////////////////////////////////////
  // immediate formats
  //////////////////////////////////////////////////

  // I-type, imm[11:0] = insn[31:20], sign extended
  function automatic logic [31:0] imm_i(input logic [31:0] insn);
    return {{20{insn[31]}}, insn[31:20]};
  endfunction

  // U-type, imm[31:12] = insn[31:12], low bits zero
  function automatic logic [31:0] imm_u(input logic [31:0] insn);
    return {insn[31:12], 12'h000};
  endfunction

endpackage

//--- src/r5p_ctl_pkg.sv
// decoded control record for the execute cluster
// operand select, operation and result sign enums

package r5p_ctl_pkg;

  //////////////////////////////////////////////////
  // operand select
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    AI_R1_R2 = 2'd0,  // rs1, rs2
    AI_R1_II = 2'd1,  // rs1, I-immediate
    AI_PC_IU = 2'd2,  // pc, U-immediate (AUIPC)
    AI_Z_IU  = 2'd3   // zero, U-immediate (LUI)
  } ai_t;

  //////////////////////////////////////////////////
  // ALU operation
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    AO_ADD  = 4'd0,
    AO_SUB  = 4'd1,
    AO_SLT  = 4'd2,
    AO_SLTU = 4'd3,
    AO_AND  = 4'd4,
    AO_OR   = 4'd5,
    AO_XOR  = 4'd6,
    AO_SLL  = 4'd7,
    AO_SRL  = 4'd8,
    AO_SRA  = 4'd9
  } ao_t;

  // adder operand extension
  typedef enum logic {
    R_SX = 1'b0,  // signed
    R_UX = 1'b1   // unsigned, SLTU/SLTIU
  } rt_t;

  // record broadcast from issue to every lane
  typedef struct packed {
    ai_t         ai;
    ao_t         ao;
    rt_t         rt;
    logic [31:0] imm;  // already picked by format
    logic [4:0]  rd;   // destination index
  } ctl_t;

endpackage

//--- src/r5p_issue.sv
// issue stage with RV32I decode and illegal filter
// round-robin dispatch to the ALU lanes
`timescale 1ns/1ps

module r5p_issue import riscv_isa_pkg::*, r5p_ctl_pkg::*; #(
  parameter int unsigned XLEN  = 32,
  parameter int unsigned NLANE = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,  // one strobe per insn
  input  logic [31:0]      insn,
  input  logic [XLEN-1:0]  pc,
  input  logic [XLEN-1:0]  rs1,
  input  logic [XLEN-1:0]  rs2,
  output logic [NLANE-1:0] lane_sel,  // one-hot for one cycle
  output ctl_t             ctl,
  output logic [XLEN-1:0]  op_pc,
  output logic [XLEN-1:0]  op_rs1,
  output logic [XLEN-1:0]  op_rs2
);

  localparam int unsigned PW = (NLANE > 1) ? $clog2(NLANE) : 1;

  opcode_t    opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       is_op;     // register-register form
  logic       legal;
  ctl_t       ctl_d;
  logic [PW-1:0] ptr;    // next lane

  assign opc   = opcode_t'(insn[6:0]);
  assign f3    = insn[14:12];
  assign f7    = insn[31:25];
  assign is_op = (opc == OP);

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  always_comb begin
    ctl_d.ai  = AI_R1_R2;
    ctl_d.rt  = R_SX;
    ctl_d.imm = '0;
    ctl_d.rd  = insn[11:7];
    legal     = 1'b0;
    // operation from funct3 (OP-IMM ignores f7 except on shifts)
    case (f3)
      F3_ADD:  ctl_d.ao = (is_op && f7[5]) ? AO_SUB : AO_ADD;
      F3_SLL:  ctl_d.ao = AO_SLL;
      F3_SLT:  ctl_d.ao = AO_SLT;
      F3_SLTU: ctl_d.ao = AO_SLTU;
      F3_XOR:  ctl_d.ao = AO_XOR;
      F3_SR:   ctl_d.ao = f7[5] ? AO_SRA : AO_SRL;
      F3_OR:   ctl_d.ao = AO_OR;
      default: ctl_d.ao = AO_AND;  // F3_AND
    endcase
    if (f3 == F3_SLTU) ctl_d.rt = R_UX;  // unsigned compare
    case (opc)
      OP: begin
        ctl_d.ai = AI_R1_R2;
        // alt funct7 only on SUB and SRA
        legal = (f7 == F7_BASE) ||
                ((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR)));
      end
      OP_IMM: begin
        ctl_d.ai  = AI_R1_II;
        ctl_d.imm = imm_i(insn);
        case (f3)
          F3_SLL:  legal = (f7 == F7_BASE);
          F3_SR:   legal = (f7 == F7_BASE) || (f7 == F7_ALT);
          default: legal = 1'b1;  // f7 is immediate here
        endcase
      end
      LUI: begin
        ctl_d.ai  = AI_Z_IU;   // 0 + imm
        ctl_d.ao  = AO_ADD;
        ctl_d.rt  = R_SX;
        ctl_d.imm = imm_u(insn);
        legal     = 1'b1;
      end
      AUIPC: begin
        ctl_d.ai  = AI_PC_IU;  // pc + imm
        ctl_d.ao  = AO_ADD;
        ctl_d.rt  = R_SX;
        ctl_d.imm = imm_u(insn);
        legal     = 1'b1;
      end
      default: legal = 1'b0;   // loads, stores, branches etc. dropped
    endcase
  end

  //////////////////////////////////////////////////
  // dispatch
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_sel <= '0;
      ptr      <= '0;
    end else begin
      lane_sel <= '0;
      if (in_valid && legal) begin
        lane_sel <= NLANE'(1) << ptr;
        ptr      <= (ptr == PW'(NLANE - 1)) ? '0 : ptr + 1'b1;  // wrap
      end
    end
  end

  // broadcast payload to all lanes
  always_ff @(posedge clk) begin
    if (in_valid && legal) begin
      ctl    <= ctl_d;
      op_pc  <= pc;
      op_rs1 <= rs1;
      op_rs2 <= rs2;
    end
  end

  // every legal insn reaches exactly one lane next cycle
  a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && legal) |=> $onehot(lane_sel));

endmodule

//--- src/r5p_alu.sv
// ALU lane: operand mux, adder, shifter, logic unit
// result and destination index registered per lane
`timescale 1ns/1ps

module r5p_alu import r5p_ctl_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sel,        // this lane takes the broadcast
  input  ctl_t            ctl,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] rs1,
  input  logic [XLEN-1:0] rs2,
  output logic            res_valid,  // one-cycle pulse
  output logic [4:0]      res_rd,
  output logic [XLEN-1:0] res_data
);

  localparam int unsigned XLOG = $clog2(XLEN);

  logic [XLEN-1:0] in1;   // muxed operand 1
  logic [XLEN-1:0] in2;   // muxed operand 2
  logic [XLEN-1:0] imm;
  logic [XLEN:0]   op1;   // extended by one bit
  logic [XLEN:0]   op2;
  logic            inv;   // subtract
  logic [XLEN:0]   sum;   // top bit is less-than
  logic [XLOG-1:0] sa;    // shift amount
  logic [XLEN-1:0] rd;    // final result

  assign imm = XLEN'(ctl.imm);

  //////////////////////////////////////////////////
  // operand mux
  //////////////////////////////////////////////////

  always_comb begin
    case (ctl.ai)
      AI_R1_R2: begin
        in1 = rs1;
        in2 = rs2;
      end
      AI_R1_II: begin
        in1 = rs1;
        in2 = imm;
      end
      AI_PC_IU: begin
        in1 = pc;   // AUIPC
        in2 = imm;
      end
      default: begin
        in1 = '0;   // LUI, zero base
        in2 = imm;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////

  // sign or zero extension for the compare bit
  always_comb begin
    if (ctl.rt == R_UX) begin
      op1 = {1'b0, in1};
      op2 = {1'b0, in2};
    end else begin
      op1 = {in1[XLEN-1], in1};
      op2 = {in2[XLEN-1], in2};
    end
  end

  assign inv = (ctl.ao == AO_SUB) || (ctl.ao == AO_SLT) || (ctl.ao == AO_SLTU);

  // two's complement subtract via invert and carry in
  assign sum = op1 + (inv ? ~op2 : op2) + (XLEN+1)'(inv);

  //////////////////////////////////////////////////
  // shifter and result mux
  //////////////////////////////////////////////////

  // register amount for OP, shamt field for OP-IMM
  assign sa = (ctl.ai == AI_R1_R2) ? rs2[XLOG-1:0] : imm[XLOG-1:0];

  always_comb begin
    case (ctl.ao)
      AO_ADD,
      AO_SUB:  rd = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: rd = XLEN'(sum[XLEN]);       // sign of difference
      AO_AND:  rd = in1 & in2;
      AO_OR:   rd = in1 | in2;
      AO_XOR:  rd = in1 ^ in2;
      AO_SLL:  rd = in1 << sa;
      AO_SRL:  rd = in1 >> sa;
      AO_SRA:  rd = $unsigned($signed(in1) >>> sa);  // arithmetic
      default: rd = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) res_valid <= 1'b0;
    else        res_valid <= sel;  // one edge behind sel
  end

  always_ff @(posedge clk) begin
    if (sel) begin
      res_rd   <= ctl.rd;
      res_data <= rd;
    end
  end

  // issue must hand over a real operation with every select
  a_ao_known: assert property (@(posedge clk) disable iff (!rst_n)
    sel |-> (!$isunknown(ctl.ao) &&
             (ctl.ao inside {AO_ADD, AO_SUB, AO_SLT, AO_SLTU, AO_AND,
                             AO_OR, AO_XOR, AO_SLL, AO_SRL, AO_SRA})));

endmodule

//--- src/r5p_retire.sv
// retire stage: merges lane results in issue order
// x0 write suppression and retired-instruction counter
`timescale 1ns/1ps

module r5p_retire #(
  parameter int unsigned NLANE = 4,
  parameter int unsigned XLEN  = 32
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NLANE-1:0]           res_valid,
  input  logic [NLANE-1:0][4:0]      res_rd,
  input  logic [NLANE-1:0][XLEN-1:0] res_data,
  output logic                       out_valid,
  output logic [4:0]                 out_rd,
  output logic [XLEN-1:0]            out_data,
  output logic [31:0]                instret
);

  logic            any;      // some lane finished
  logic [4:0]      mrg_rd;
  logic [XLEN-1:0] mrg_data;

  // AND-OR merge, at most one lane is valid
  always_comb begin
    mrg_rd   = '0;
    mrg_data = '0;
    for (int i = 0; i < NLANE; i++) begin
      mrg_rd   |= res_rd[i]   & {5{res_valid[i]}};
      mrg_data |= res_data[i] & {XLEN{res_valid[i]}};
    end
  end

  assign any = |res_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      instret   <= '0;
    end else begin
      out_valid <= any;
      if (any) instret <= instret + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (any) begin
      out_rd   <= mrg_rd;
      out_data <= (mrg_rd == 5'd0) ? '0 : mrg_data;  // x0 reads as zero
    end
  end

  // round-robin issue keeps lanes from finishing together
  a_one_lane: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(res_valid));

endmodule

//--- src/r5p_exu.sv
// execute cluster top level
// issue, NLANE ALU lanes and retire
`timescale 1ns/1ps

module r5p_exu import r5p_ctl_pkg::*; #(
  parameter int unsigned XLEN  = 32,
  parameter int unsigned NLANE = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  logic [31:0]     insn,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] rs1,
  input  logic [XLEN-1:0] rs2,
  output logic            out_valid,  // 3 edges after in_valid
  output logic [4:0]      out_rd,
  output logic [XLEN-1:0] out_data,
  output logic [31:0]     instret
);

  logic [NLANE-1:0]           lane_sel;
  ctl_t                       ctl;       // broadcast to all lanes
  logic [XLEN-1:0]            op_pc;
  logic [XLEN-1:0]            op_rs1;
  logic [XLEN-1:0]            op_rs2;
  logic [NLANE-1:0]           res_valid;
  logic [NLANE-1:0][4:0]      res_rd;
  logic [NLANE-1:0][XLEN-1:0] res_data;

  r5p_issue #(.XLEN(XLEN), .NLANE(NLANE)) i_issue (
    .clk, .rst_n, .in_valid, .insn, .pc, .rs1, .rs2,
    .lane_sel, .ctl, .op_pc, .op_rs1, .op_rs2
  );

  for (genvar l = 0; l < NLANE; l++) begin : gen_lane
    r5p_alu #(.XLEN(XLEN)) i_alu (
      .clk, .rst_n,
      .sel       (lane_sel[l]),
      .ctl,
      .pc        (op_pc),
      .rs1       (op_rs1),
      .rs2       (op_rs2),
      .res_valid (res_valid[l]),
      .res_rd    (res_rd[l]),
      .res_data  (res_data[l])
    );
  end

  r5p_retire #(.NLANE(NLANE), .XLEN(XLEN)) i_retire (
    .clk, .rst_n, .res_valid, .res_rd, .res_data,
    .out_valid, .out_rd, .out_data, .instret
  );

endmodule

//--- dv/tb_r5p_exu.sv
// testbench for the execute cluster
// random RV32I stimulus, reference model with result queue, timeout
`timescale 1ns/1ps

module tb_r5p_exu import riscv_isa_pkg::*;;

  localparam int RST_CYC = 8;
  localparam int NSTIM   = 400;                  // stimulus cycles
  localparam int LIMIT   = RST_CYC + NSTIM + 50;  // timeout in cycles

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [31:0] insn;
  logic [31:0] pc;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic        out_valid;
  logic [4:0]  out_rd;
  logic [31:0] out_data;
  logic [31:0] instret;

  integer      seed = 22;
  int          cyc = 0;       // rising edges seen
  int          nlegal = 0;    // legal insns issued
  int          nret = 0;      // results seen at the output
  logic [4:0]  exp_rd[$];     // expected results in issue order
  logic [31:0] exp_val[$];
  int          exp_cyc[$];    // cycle of issue

  r5p_exu #(.XLEN(32), .NLANE(4)) i_dut (
    .clk, .rst_n, .in_valid, .insn, .pc, .rs1, .rs2,
    .out_valid, .out_rd, .out_data, .instret
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) stop_on_error("timeout, results did not drain in time");
  end

  //////////////////////////////////////////////////
  // error handling
  //////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    string line;
    if (got !== exp) begin
      line = $sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error(line);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model with RV32I semantics
  //////////////////////////////////////////////////

  // returns 0 for anything outside OP/OP-IMM/LUI/AUIPC
  function automatic logic ref_exec(input logic [31:0] w, input logic [31:0] p,
                                    input logic [31:0] a, input logic [31:0] b,
                                    output logic [31:0] res);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] y;    // second operand
    logic [4:0]  sh;   // shift amount
    logic        alt;  // SUB or SRA
    f3  = w[14:12];
    f7  = w[31:25];
    res = '0;
    if (w[6:0] == LUI) begin
      res = imm_u(w);
      return 1'b1;
    end
    if (w[6:0] == AUIPC) begin
      res = p + imm_u(w);
      return 1'b1;
    end
    if (w[6:0] == OP) begin
      // funct7 0x20 only for SUB and SRA
      if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) return 1'b0;
      y   = b;
      sh  = b[4:0];
      alt = f7[5];
    end else if (w[6:0] == OP_IMM) begin
      if (f3 == 3'd1 && f7 != 7'h00) return 1'b0;                 // SLLI
      if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) return 1'b0;  // SRLI/SRAI
      y   = imm_i(w);
      sh  = w[24:20];  // shamt field
      alt = (f3 == 3'd5) && f7[5];
    end else begin
      return 1'b0;
    end
    case (f3)
      3'd0: res = alt ? a - y : a + y;
      3'd1: res = a << sh;
      3'd2: res = {31'd0, $signed(a) < $signed(y)};
      3'd3: res = {31'd0, a < y};
      3'd4: res = a ^ y;
      3'd5: begin
        if (alt) res = $signed(a) >>> sh;
        else     res = a >> sh;
      end
      3'd6: res = a | y;
      default: res = a & y;
    endcase
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // mostly legal encodings with a few illegal ones
  task automatic gen_insn(output logic [31:0] w);
    logic [31:0] r;
    logic [3:0]  kind;
    r        = $random(seed);
    kind     = r[3:0];
    w        = $random(seed);  // random immediates and rs fields
    w[11:7]  = (r[6:4] == 3'd0) ? 5'd0 : r[11:7];  // x0 now and then
    w[14:12] = r[14:12];
    if (kind <= 4'd6) begin
      w[6:0]   = OP;
      w[31:25] = (r[15] && (r[14:12] == 3'd0 || r[14:12] == 3'd5)) ? F7_ALT : F7_BASE;
    end else if (kind <= 4'd11) begin
      w[6:0] = OP_IMM;
      if (r[14:12] == 3'd1)      w[31:25] = F7_BASE;
      else if (r[14:12] == 3'd5) w[31:25] = r[15] ? F7_ALT : F7_BASE;
    end else if (kind == 4'd12) begin
      w[6:0] = LUI;
    end else if (kind == 4'd13) begin
      w[6:0] = AUIPC;
    end else if (kind == 4'd14) begin
      case (r[17:16])  // load, store, branch, jal
        2'd0:    w[6:0] = 7'b0000011;
        2'd1:    w[6:0] = 7'b0100011;
        2'd2:    w[6:0] = 7'b1100011;
        default: w[6:0] = 7'b1101111;
      endcase
    end else begin
      w[6:0]   = OP;  // bad funct7
      w[31:25] = r[16] ? 7'b0000001 : F7_ALT;
      w[14:12] = 3'd6;
    end
  endtask

  // random value with boundary values one time in eight
  task automatic gen_operand(output logic [31:0] v);
    logic [31:0] r;
    r = $random(seed);
    if (r[2:0] == 3'd0) begin
      case (r[5:3])
        3'd0:    v = 32'h0000_0000;
        3'd1:    v = 32'h0000_0001;
        3'd2:    v = 32'h7fff_ffff;
        3'd3:    v = 32'h8000_0000;
        3'd4:    v = 32'hffff_ffff;
        3'd5:    v = 32'h8000_0001;
        3'd6:    v = 32'hffff_fffe;
        default: v = 32'h0000_001f;
      endcase
    end else begin
      v = $random(seed);
    end
  endtask

  // sample at the falling edge and pop one expected result
  task automatic check_outputs();
    if (out_valid) begin
      if (exp_rd.size() == 0) begin
        stop_on_error("out_valid high while no result was expected");
      end else begin
        nret++;
        check("out_rd", {27'd0, out_rd}, {27'd0, exp_rd[0]});
        check("out_data", out_data, exp_val[0]);
        check("out_valid latency", 32'(cyc - exp_cyc[0]), 32'd3);
        check("instret", instret, 32'(nret));
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
        void'(exp_cyc.pop_front());
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] p;
    logic [31:0] res;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    insn     = '0;
    pc       = '0;
    rs1      = '0;
    rs2      = '0;
    repeat (RST_CYC) @(negedge clk);
    check("out_valid", {31'd0, out_valid}, 32'd0);
    check("instret", instret, 32'd0);
    rst_n = 1'b1;

    for (int n = 0; n < NSTIM; n++) begin
      @(negedge clk);
      check_outputs();
      in_valid = 1'b0;
      r = $random(seed);
      if (r[2:0] != 3'd0) begin  // idle one cycle in eight
        gen_insn(w);
        gen_operand(a);
        gen_operand(b);
        p = {r[31:2], 2'b00};
        in_valid = 1'b1;
        insn     = w;
        pc       = p;
        rs1      = a;
        rs2      = b;
        if (ref_exec(w, p, a, b, res)) begin
          if (w[11:7] == 5'd0) res = '0;  // x0 reads as zero
          exp_rd.push_back(w[11:7]);
          exp_val.push_back(res);
          exp_cyc.push_back(cyc);
          nlegal++;
        end
      end
    end

    // pipeline is three edges deep so every result leaves within the drain
    @(negedge clk);
    check_outputs();
    in_valid = 1'b0;
    repeat (6) begin
      @(negedge clk);
      check_outputs();
    end

    if (exp_rd.size() != 0) begin
      stop_on_error("results still expected at the end of the run");
    end else begin
      check("instret", instret, 32'(nlegal));
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- build.f
src/riscv_isa_pkg.sv
src/r5p_ctl_pkg.sv
src/r5p_issue.sv
src/r5p_alu.sv
src/r5p_retire.sv
src/r5p_exu.sv
dv/tb_r5p_exu.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_r5p_exu

verilator --binary --timing --assert -f build.f --top-module "$TOP" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

exit 0
